//--- source/hdr_proc_macros.svh
`ifndef HP_PROC_MACROS_SVH
`define HP_PROC_MACROS_SVH

// ====================
// stream geometry
// ====================

// bytes carried by one beat.
`define HP_DATA_BYTES 4

// width of the tid field.
`define HP_ID_BITS 2

// width of the tdest field.
`define HP_DEST_BITS 2

// ====================
// limits
// ====================

// most prefix words placed before a packet.
`define HP_MAX_PREFIX_WORDS 4

// width of byte length fields and byte counters.
`define HP_LEN_BITS 8

// default packet FIFO depth, in beats.
`define HP_FIFO_DEPTH 64

`endif

//--- source/hdr_proc_pkg.sv
`include "hdr_proc_macros.svh"

package hdr_proc_pkg;

   // ====================
   // stream types
   // ====================

   // one data word, byte lane 0 in bits 7 to 0.
   typedef logic [`HP_DATA_BYTES*8-1:0] hdr_word_t;

   // one stream beat as it travels between the stages.
   typedef struct packed {
      hdr_word_t                  data;
      logic [`HP_DATA_BYTES-1:0]  keep;
      logic                       last;
      logic [`HP_ID_BITS-1:0]     tid;
      logic [`HP_DEST_BITS-1:0]   tdest;
   } hdr_beat_t;

   // prefix words, word 0 leaves first.
   typedef hdr_word_t [`HP_MAX_PREFIX_WORDS-1:0] prefix_words_t;

   // ====================
   // modes and states
   // ====================

   // marker keeps one empty last beat, whole removes everything.
   typedef enum logic {
      DROP_MARKER = 1'b0,
      DROP_WHOLE  = 1'b1
   } drop_mode_e;

   // prefix inserter FSM.
   typedef enum logic [1:0] {
      PREFIX_IDLE = 2'd0,
      PREFIX_EMIT = 2'd1,
      PREFIX_BODY = 2'd2
   } prefix_state_e;

   // truncator FSM.
   typedef enum logic {
      TRUNC_PASS    = 1'b0,
      TRUNC_DISCARD = 1'b1
   } trunc_state_e;

endpackage

//--- source/hdr_drop_filter.sv
module hdr_drop_filter (
   input  logic                       axi4s_in,
   input  logic                       reset,
   input  hdr_proc_pkg::hdr_beat_t    in_beat,
   input  logic                       in_valid,
   output logic                       in_ready,
   input  logic                       drop_en,
   input  hdr_proc_pkg::drop_mode_e   drop_mode,
   input  hdr_proc_pkg::hdr_word_t    drop_word,
   output hdr_proc_pkg::hdr_beat_t    out_beat,
   output logic                       out_valid,
   input  logic                       out_ready
);

   // high while the next input beat opens a packet.
   logic sop;
   // holds the drop decision for the rest of the packet.
   logic drop_latch;
   // first beat matches the drop word.
   logic match;
   logic in_fire;

   assign match   = drop_en && sop && in_valid && (in_beat.data == drop_word);
   assign in_fire = in_valid && in_ready;

   // ====================
   // datapath
   // ====================
   always_comb begin
      out_beat  = in_beat;
      out_valid = in_valid;
      in_ready  = out_ready;
      if (drop_latch) begin
         // tail of a dropped packet, swallowed here.
         out_valid = 1'b0;
         in_ready  = 1'b1;
      end else if (match) begin
         if (drop_mode == hdr_proc_pkg::DROP_WHOLE) begin
            out_valid = 1'b0;
            in_ready  = 1'b1;
         end else begin
            // marker beat closes the packet with no bytes.
            out_beat.keep = '0;
            out_beat.last = 1'b1;
         end
      end
   end

   // ====================
   // packet tracking
   // ====================
   always_ff @(posedge axi4s_in) begin
      if (reset) begin
         sop        <= 1'b1;
         drop_latch <= 1'b0;
      end else if (in_fire) begin
         // input last opens the next packet.
         sop <= in_beat.last;
         if (in_beat.last) begin
            drop_latch <= 1'b0;
         end else if (match) begin
            drop_latch <= 1'b1;
         end
      end
   end

endmodule

//--- source/hdr_prefix_insert.sv
`include "hdr_proc_macros.svh"

module hdr_prefix_insert (
   input  logic                          axi4s_in,
   input  logic                          reset,
   input  hdr_proc_pkg::hdr_beat_t       in_beat,
   input  logic                          in_valid,
   output logic                          in_ready,
   input  logic [2:0]                    prefix_count,
   input  hdr_proc_pkg::prefix_words_t   prefix_data,
   output hdr_proc_pkg::hdr_beat_t       out_beat,
   output logic                          out_valid,
   input  logic                          out_ready
);

   localparam int IDX_BITS = $clog2(`HP_MAX_PREFIX_WORDS);

   // pipe register.
   hdr_proc_pkg::hdr_beat_t pipe_beat;
   logic                    pipe_valid;
   // the held beat leaves this cycle.
   logic                    pipe_take;

   hdr_proc_pkg::prefix_state_e state;
   // next prefix word to send.
   logic [IDX_BITS-1:0]         word_idx;
   // a prefix word sits on the output instead of the held beat.
   logic                        emit;
   logic                        last_word;
   logic                        out_fire;

   // prefix starts as soon as a first beat is held.
   assign emit = pipe_valid && ((state == hdr_proc_pkg::PREFIX_EMIT) ||
                                ((state == hdr_proc_pkg::PREFIX_IDLE) && (prefix_count != 3'd0)));
   assign last_word = (3'(word_idx) + 3'd1 == prefix_count);

   assign out_fire  = pipe_valid && out_ready;
   assign pipe_take = out_fire && !emit;
   // input stalls while prefix words go out.
   assign in_ready  = !pipe_valid || pipe_take;

   // ====================
   // output mux
   // ====================
   always_comb begin
      out_valid = pipe_valid;
      out_beat  = pipe_beat;
      if (emit) begin
         out_beat.data = prefix_data[word_idx];
         out_beat.keep = '1;
         out_beat.last = 1'b0;
         // tid and tdest come from the held beat.
      end
   end

   // ====================
   // pipe register
   // ====================
   always_ff @(posedge axi4s_in) begin
      if (reset) begin
         pipe_valid <= 1'b0;
      end else if (in_ready) begin
         pipe_valid <= in_valid;
      end
   end

   // payload, loaded with each accepted beat.
   always_ff @(posedge axi4s_in) begin
      if (in_ready && in_valid) begin
         pipe_beat <= in_beat;
      end
   end

   // ====================
   // prefix FSM
   // ====================
   always_ff @(posedge axi4s_in) begin
      if (reset) begin
         state    <= hdr_proc_pkg::PREFIX_IDLE;
         word_idx <= '0;
      end else if (out_fire) begin
         if (emit) begin
            if (last_word) begin
               word_idx <= '0;
               state    <= hdr_proc_pkg::PREFIX_BODY;
            end else begin
               word_idx <= word_idx + 1'b1;
               state    <= hdr_proc_pkg::PREFIX_EMIT;
            end
         end else if (pipe_beat.last) begin
            state <= hdr_proc_pkg::PREFIX_IDLE;
         end else begin
            state <= hdr_proc_pkg::PREFIX_BODY;
         end
      end
   end

endmodule

//--- source/hdr_trunc.sv
`include "hdr_proc_macros.svh"

module hdr_trunc (
   input  logic                       axi4s_in,
   input  logic                       reset,
   input  hdr_proc_pkg::hdr_beat_t    in_beat,
   input  logic                       in_valid,
   output logic                       in_ready,
   input  logic [`HP_LEN_BITS-1:0]    trunc_len,
   output hdr_proc_pkg::hdr_beat_t    out_beat,
   output logic                       out_valid,
   input  logic                       out_ready
);

   localparam int NUM_BITS = $clog2(`HP_DATA_BYTES + 1);

   hdr_proc_pkg::trunc_state_e state;
   // bytes already sent in this packet.
   logic [`HP_LEN_BITS-1:0]    byte_cnt;
   // one bit wider to catch a wrap.
   logic [`HP_LEN_BITS:0]      cnt_next;
   logic [`HP_LEN_BITS-1:0]    remaining;
   logic [NUM_BITS-1:0]        beat_bytes;
   // this beat reaches the length.
   logic                       cut;
   logic                       in_fire;

   assign in_fire = in_valid && in_ready;

   // ====================
   // byte count
   // ====================
   always_comb begin
      beat_bytes = '0;
      for (int i = 0; i < `HP_DATA_BYTES; i++) begin
         beat_bytes = beat_bytes + NUM_BITS'(in_beat.keep[i]);
      end
      cnt_next  = {1'b0, byte_cnt} + (`HP_LEN_BITS+1)'(beat_bytes);
      remaining = trunc_len - byte_cnt;
      // zero keep beats never cut.
      cut = (trunc_len != '0) && (|in_beat.keep) && (cnt_next >= {1'b0, trunc_len});
   end

   // ====================
   // datapath
   // ====================
   always_comb begin
      out_beat  = in_beat;
      out_valid = in_valid;
      in_ready  = out_ready;
      if (state == hdr_proc_pkg::TRUNC_DISCARD) begin
         out_valid = 1'b0;
         in_ready  = 1'b1;
      end else if (cut) begin
         // keep only lanes below the remaining byte count.
         for (int i = 0; i < `HP_DATA_BYTES; i++) begin
            out_beat.keep[i] = in_beat.keep[i] && (`HP_LEN_BITS'(i) < remaining);
         end
         out_beat.last = 1'b1;
      end
   end

   always_ff @(posedge axi4s_in) begin
      if (reset) begin
         state    <= hdr_proc_pkg::TRUNC_PASS;
         byte_cnt <= '0;
      end else if (in_fire) begin
         if (state == hdr_proc_pkg::TRUNC_DISCARD) begin
            if (in_beat.last) begin
               state <= hdr_proc_pkg::TRUNC_PASS;
            end
         end else begin
            // tail still to come, throw it away.
            if (cut && !in_beat.last) begin
               state <= hdr_proc_pkg::TRUNC_DISCARD;
            end
            if (cut || in_beat.last) begin
               byte_cnt <= '0;
            end else begin
               byte_cnt <= cnt_next[`HP_LEN_BITS-1:0];
            end
         end
      end
   end

endmodule

//--- source/hdr_pkt_fifo.sv
`include "hdr_proc_macros.svh"

module hdr_pkt_fifo #(
   parameter int FIFO_DEPTH = `HP_FIFO_DEPTH
) (
   input  logic                       axi4s_in,
   input  logic                       reset,
   input  hdr_proc_pkg::hdr_beat_t    in_beat,
   input  logic                       in_valid,
   output logic                       in_ready,
   output hdr_proc_pkg::hdr_beat_t    out_beat,
   output logic                       out_valid,
   input  logic                       out_ready
);

   localparam int PTR_BITS = (FIFO_DEPTH > 1) ? $clog2(FIFO_DEPTH) : 1;
   localparam int CNT_BITS = $clog2(FIFO_DEPTH + 1);

   // ====================
   // storage
   // ====================

   // beat buffer.
   hdr_proc_pkg::hdr_beat_t mem [FIFO_DEPTH];

   logic [PTR_BITS-1:0] wr_ptr;
   logic [PTR_BITS-1:0] rd_ptr;
   // beats stored.
   logic [CNT_BITS-1:0] word_cnt;
   // complete packets stored.
   logic [CNT_BITS-1:0] pkt_cnt;

   logic wr_fire;
   logic rd_fire;
   // packet boundaries on either side.
   logic wr_eop;
   logic rd_eop;

   assign in_ready  = (word_cnt != CNT_BITS'(FIFO_DEPTH));
   // nothing leaves until a whole packet is in.
   assign out_valid = (pkt_cnt != '0);
   assign out_beat  = mem[rd_ptr];

   assign wr_fire = in_valid && in_ready;
   assign rd_fire = out_valid && out_ready;
   assign wr_eop  = wr_fire && in_beat.last;
   assign rd_eop  = rd_fire && out_beat.last;

   always_ff @(posedge axi4s_in) begin
      if (wr_fire) begin
         mem[wr_ptr] <= in_beat;
      end
   end

   // ====================
   // pointers and counts
   // ====================
   always_ff @(posedge axi4s_in) begin
      if (reset) begin
         wr_ptr <= '0;
         rd_ptr <= '0;
      end else begin
         // pointers wrap at the depth.
         if (wr_fire) begin
            wr_ptr <= (wr_ptr == PTR_BITS'(FIFO_DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
         end
         if (rd_fire) begin
            rd_ptr <= (rd_ptr == PTR_BITS'(FIFO_DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
         end
      end
   end

   always_ff @(posedge axi4s_in) begin
      if (reset) begin
         word_cnt <= '0;
         pkt_cnt  <= '0;
      end else begin
         case ({wr_fire, rd_fire})
            2'b10:   word_cnt <= word_cnt + 1'b1;
            2'b01:   word_cnt <= word_cnt - 1'b1;
            default: word_cnt <= word_cnt;
         endcase
         // counted at the write edge, so valid follows a cycle later.
         case ({wr_eop, rd_eop})
            2'b10:   pkt_cnt <= pkt_cnt + 1'b1;
            2'b01:   pkt_cnt <= pkt_cnt - 1'b1;
            default: pkt_cnt <= pkt_cnt;
         endcase
      end
   end

endmodule

//--- source/hdr_proc.sv
`include "hdr_proc_macros.svh"

module hdr_proc (
   input  logic                          axi4s_in,
   input  logic                          reset,
   input  hdr_proc_pkg::hdr_beat_t       in_beat,
   input  logic                          in_valid,
   output logic                          in_ready,
   input  logic                          drop_en,
   input  hdr_proc_pkg::drop_mode_e      drop_mode,
   input  hdr_proc_pkg::hdr_word_t       drop_word,
   input  logic [2:0]                    prefix_count,
   input  hdr_proc_pkg::prefix_words_t   prefix_data,
   input  logic [`HP_LEN_BITS-1:0]       trunc_len,
   output hdr_proc_pkg::hdr_beat_t       out_beat,
   output logic                          out_valid,
   input  logic                          out_ready
);

   // ====================
   // stage links
   // ====================

   // drop filter to prefix inserter.
   hdr_proc_pkg::hdr_beat_t drop_beat;
   logic                    drop_valid;
   logic                    drop_ready;

   // prefix inserter to truncator.
   hdr_proc_pkg::hdr_beat_t pre_beat;
   logic                    pre_valid;
   logic                    pre_ready;

   // truncator to packet FIFO.
   hdr_proc_pkg::hdr_beat_t trunc_beat;
   logic                    trunc_valid;
   logic                    trunc_ready;

   hdr_drop_filter u_drop (
      .axi4s_in   (axi4s_in),   .reset      (reset),
      .in_beat    (in_beat),    .in_valid   (in_valid),   .in_ready   (in_ready),
      .drop_en    (drop_en),    .drop_mode  (drop_mode),  .drop_word  (drop_word),
      .out_beat   (drop_beat),  .out_valid  (drop_valid), .out_ready  (drop_ready)
   );

   hdr_prefix_insert u_prefix (
      .axi4s_in     (axi4s_in),     .reset        (reset),
      .in_beat      (drop_beat),    .in_valid     (drop_valid), .in_ready (drop_ready),
      .prefix_count (prefix_count), .prefix_data  (prefix_data),
      .out_beat     (pre_beat),     .out_valid    (pre_valid),  .out_ready (pre_ready)
   );

   hdr_trunc u_trunc (
      .axi4s_in   (axi4s_in),   .reset      (reset),
      .in_beat    (pre_beat),   .in_valid   (pre_valid),   .in_ready   (pre_ready),
      .trunc_len  (trunc_len),
      .out_beat   (trunc_beat), .out_valid  (trunc_valid), .out_ready  (trunc_ready)
   );

   // holds whole packets until their last beat is in.
   hdr_pkt_fifo #(.FIFO_DEPTH(`HP_FIFO_DEPTH)) u_fifo (
      .axi4s_in   (axi4s_in),   .reset      (reset),
      .in_beat    (trunc_beat), .in_valid   (trunc_valid), .in_ready   (trunc_ready),
      .out_beat   (out_beat),   .out_valid  (out_valid),   .out_ready  (out_ready)
   );

endmodule

//--- sim/hdr_proc_properties.sv
module hdr_proc_properties (
   input logic                      axi4s_in,
   input logic                      reset,
   input hdr_proc_pkg::hdr_beat_t   out_beat,
   input logic                      out_valid,
   input logic                      out_ready
);
   timeunit 1ns;
   timeprecision 100ps;

   // ====================
   // output stream rules
   // ====================

   // the FIFO comes out of reset empty.
   valid_low_after_reset: assert property (@(posedge axi4s_in) reset |=> !out_valid)
      else $error("out_valid is high in the cycle after reset");

   // a stalled beat must not move or change.
   beat_held_on_stall: assert property (@(posedge axi4s_in) disable iff (reset)
      (out_valid && !out_ready) |=> (out_valid && $stable(out_beat)))
      else $error("out_beat or out_valid changed while out_ready was low");

   // keep is 0, 1, 3, 7 or f; an empty beat must close the packet.
   keep_from_lane0: assert property (@(posedge axi4s_in) disable iff (reset)
      out_valid |-> (((out_beat.keep & (out_beat.keep + 1'b1)) == '0) &&
                     ((out_beat.keep != '0) || out_beat.last)))
      else $error("out_beat.keep is not contiguous from lane 0 or is empty without last");

endmodule

bind hdr_proc hdr_proc_properties u_props (
   .axi4s_in  (axi4s_in),
   .reset     (reset),
   .out_beat  (out_beat),
   .out_valid (out_valid),
   .out_ready (out_ready)
);

//--- sim/hdr_proc_tb.sv
`include "hdr_proc_macros.svh"

module hdr_proc_tb;
   timeunit 1ns;
   timeprecision 100ps;

   localparam hdr_proc_pkg::drop_mode_e MARK  = hdr_proc_pkg::DROP_MARKER;
   localparam hdr_proc_pkg::drop_mode_e WHOLE = hdr_proc_pkg::DROP_WHOLE;
   localparam int NUM_ROWS = 15;
   localparam int NB = `HP_DATA_BYTES;

   // one stimulus row; len 0 sweeps packet k over k+1 bytes.
   typedef struct {
      string                    name;
      int                       pkts;
      int                       len;
      bit                       drop_en;
      hdr_proc_pkg::drop_mode_e mode;
      bit                       match;
      int                       prefix;
      int                       trunc;
      bit                       stall;
   } row_t;

   // ====================
   // stimulus table
   // ====================
   // with match set, even packets carry the drop word.
   row_t rows [NUM_ROWS] = '{
      '{"pass_sweep",     64,  0, 0, MARK,  0, 0,  0, 0},
      '{"prefix_1",        6, 13, 0, MARK,  0, 1,  0, 0},
      '{"prefix_4",        6, 64, 0, MARK,  0, 4,  0, 0},
      '{"trunc_1",         6, 10, 0, MARK,  0, 0,  1, 0},
      '{"trunc_20_pfx2",   6, 30, 0, MARK,  0, 2, 20, 0},
      '{"trunc_7_pfx3",    6,  5, 0, MARK,  0, 3,  7, 0},
      '{"trunc_short",     4, 18, 0, MARK,  0, 0, 20, 0},
      '{"drop_marker",     8, 11, 1, MARK,  1, 0,  0, 0},
      '{"drop_whole",      8, 23, 1, WHOLE, 1, 0,  0, 0},
      '{"drop_off",        4,  9, 0, WHOLE, 1, 0,  0, 0},
      '{"pass_sweep_bp",  64,  0, 0, MARK,  0, 0,  0, 1},
      '{"prefix_3_bp",     6, 21, 0, MARK,  0, 3,  0, 1},
      '{"trunc_13_bp",     6, 27, 0, MARK,  0, 1, 13, 1},
      '{"drop_marker_bp",  8, 11, 1, MARK,  1, 0,  0, 1},
      '{"drop_whole_bp",   8, 23, 1, WHOLE, 1, 0,  0, 1}
   };

   logic                        axi4s_in;
   logic                        reset;
   hdr_proc_pkg::hdr_beat_t     in_beat;
   logic                        in_valid;
   logic                        in_ready;
   logic                        drop_en;
   hdr_proc_pkg::drop_mode_e    drop_mode;
   hdr_proc_pkg::hdr_word_t     drop_word;
   logic [2:0]                  prefix_count;
   hdr_proc_pkg::prefix_words_t prefix_data;
   logic [`HP_LEN_BITS-1:0]     trunc_len;
   hdr_proc_pkg::hdr_beat_t     out_beat;
   logic                        out_valid;
   logic                        out_ready;

   // beats the output still owes, oldest first.
   hdr_proc_pkg::hdr_beat_t exp_q [$];
   logic [7:0]  pkt_bytes [68];
   logic [7:0]  out_bytes [96];
   logic [31:0] data_seed  = 32'ha4a86637;
   logic [31:0] stall_seed = 32'ha4a86637;
   bit          stall_en;
   string       cur_name = "reset";
   int          mismatch_cnt;
   int          extra_cnt;
   int          cycle_cnt;
   int          cycle_limit = 1000000;

   hdr_proc i_dut (.*);

   initial begin
      axi4s_in = 1'b0;
      forever #10 axi4s_in = ~axi4s_in;
   end

   function automatic logic [31:0] lcg_next(input logic [31:0] s);
      return s * 32'd1664525 + 32'd1013904223;
   endfunction

   // data is compared only on kept lanes.
   function automatic bit beat_match(input hdr_proc_pkg::hdr_beat_t exp,
                                     input hdr_proc_pkg::hdr_beat_t act);
      hdr_proc_pkg::hdr_word_t mask;
      for (int j = 0; j < NB; j++) begin
         mask[8*j +: 8] = {8{exp.keep[j]}};
      end
      return ((exp.data & mask) == (act.data & mask)) && (exp.keep == act.keep) &&
             (exp.last == act.last) && (exp.tid == act.tid) && (exp.tdest == act.tdest);
   endfunction

   // ====================
   // reference model
   // ====================
   task automatic push_expected(input int r, input int len, input bit hit,
                                input logic [1:0] id);
      int n;
      hdr_proc_pkg::hdr_beat_t b;
      if (hit && rows[r].drop_en) begin
         // marker leaves one empty closing beat, whole leaves nothing.
         if (rows[r].mode == MARK) begin
            b = '0;
            b.last  = 1'b1;
            b.tid   = id;
            b.tdest = ~id;
            exp_q.push_back(b);
         end
      end else begin
         n = 0;
         for (int w = 0; w < rows[r].prefix; w++) begin
            for (int j = 0; j < NB; j++) begin
               out_bytes[n] = prefix_data[w][8*j +: 8];
               n++;
            end
         end
         for (int i = 0; i < len; i++) begin
            out_bytes[n] = pkt_bytes[i];
            n++;
         end
         if (rows[r].trunc != 0 && n > rows[r].trunc) begin
            n = rows[r].trunc;
         end
         // pack from lane 0, last on the final beat.
         for (int i = 0; i < n; i += NB) begin
            b = '0;
            for (int j = 0; j < NB; j++) begin
               if (i + j < n) begin
                  b.data[8*j +: 8] = out_bytes[i+j];
                  b.keep[j] = 1'b1;
               end
            end
            b.last  = (i + NB >= n);
            b.tid   = id;
            b.tdest = ~id;
            exp_q.push_back(b);
         end
      end
   endtask

   // ====================
   // packet driver
   // ====================
   task automatic send_packet(input int r, input int k);
      int len;
      int nbeats;
      bit hit;
      bit acc;
      logic [1:0] id;
      hdr_proc_pkg::hdr_word_t first;
      hdr_proc_pkg::hdr_beat_t b;
      len    = (rows[r].len == 0) ? k + 1 : rows[r].len;
      nbeats = (len + NB - 1) / NB;
      hit    = rows[r].match && (k % 2 == 0);
      id     = 2'(k);
      // lanes past the length are filler, so the first word is always full.
      for (int i = 0; i < 68; i++) begin
         data_seed = lcg_next(data_seed);
         pkt_bytes[i] = data_seed[23:16];
      end
      first = {pkt_bytes[3], pkt_bytes[2], pkt_bytes[1], pkt_bytes[0]};
      if (hit) begin
         for (int j = 0; j < NB; j++) begin
            pkt_bytes[j] = drop_word[8*j +: 8];
         end
      end else if (first == drop_word) begin
         pkt_bytes[0] = ~pkt_bytes[0];
      end
      push_expected(r, len, hit, id);
      for (int bt = 0; bt < nbeats; bt++) begin
         b = '0;
         for (int j = 0; j < NB; j++) begin
            b.data[8*j +: 8] = pkt_bytes[NB*bt+j];
            b.keep[j] = (NB * bt + j < len);
         end
         b.last   = (bt == nbeats - 1);
         b.tid    = id;
         b.tdest  = ~id;
         in_beat  = b;
         in_valid = 1'b1;
         // ready is settled by the falling edge.
         acc = 1'b0;
         while (!acc) begin
            @(negedge axi4s_in);
            acc = in_ready;
            @(posedge axi4s_in);
            #2;
         end
      end
      in_valid = 1'b0;
   endtask

   // ====================
   // output side
   // ====================
   always @(posedge axi4s_in) begin
      #2;
      stall_seed = lcg_next(stall_seed);
      out_ready  = stall_en ? stall_seed[24] : 1'b1;
   end

   // a transfer seen at the falling edge completes on the next rising edge.
   always @(negedge axi4s_in) begin
      if (!reset && out_valid && out_ready) begin
         assert (exp_q.size() != 0) else begin
            $display("unexpected output beat %h in test %s", out_beat, cur_name);
            extra_cnt++;
         end
         if (exp_q.size() != 0) begin
            assert (beat_match(exp_q[0], out_beat)) else begin
               $display("FAIL %s: expected %h actual %h", cur_name, exp_q[0], out_beat);
               mismatch_cnt++;
            end
            void'(exp_q.pop_front());
         end
      end
   end

   always @(posedge axi4s_in) begin
      cycle_cnt++;
      if (cycle_cnt > cycle_limit) begin
         $display("timeout after %0d cycles in test %s, %0d expected beats never arrived",
                  cycle_cnt, cur_name, exp_q.size());
         $display("errors: %0d mismatched, %0d unexpected", mismatch_cnt, extra_cnt);
         $display("Test FAILED");
         $finish;
      end
   end

   // ====================
   // main sequence
   // ====================
   initial begin
      reset        = 1'b1;
      in_beat      = '0;
      in_valid     = 1'b0;
      out_ready    = 1'b1;
      stall_en     = 1'b0;
      drop_en      = 1'b0;
      drop_mode    = MARK;
      drop_word    = 32'h5a5a0ff0;
      prefix_count = 3'd0;
      trunc_len    = '0;
      prefix_data  = {32'hd3d2d1d0, 32'hc3c2c1c0, 32'hb3b2b1b0, 32'ha3a2a1a0};
      // 4 cycles per beat or prefix word, plus the settle gap of each row.
      cycle_limit = 200;
      for (int r = 0; r < NUM_ROWS; r++) begin
         cycle_limit += rows[r].pkts * (((rows[r].len == 0) ? 64 : rows[r].len) + 3) / 4 * 4
                        + rows[r].pkts * rows[r].prefix * 4 + 32;
      end
      repeat (4) @(posedge axi4s_in);
      #2;
      reset = 1'b0;
      for (int r = 0; r < NUM_ROWS; r++) begin
         cur_name     = rows[r].name;
         drop_en      = rows[r].drop_en;
         drop_mode    = rows[r].mode;
         prefix_count = 3'(rows[r].prefix);
         trunc_len    = `HP_LEN_BITS'(rows[r].trunc);
         stall_en     = rows[r].stall;
         for (int k = 0; k < rows[r].pkts; k++) begin
            send_packet(r, k);
         end
         while (exp_q.size() != 0) begin
            @(posedge axi4s_in);
         end
         // let discarded tails drain before the config moves.
         repeat (24) @(posedge axi4s_in);
         #2;
      end
      $display("errors: %0d mismatched, %0d unexpected", mismatch_cnt, extra_cnt);
      if (mismatch_cnt == 0 && extra_cnt == 0) begin
         $display("Test OK");
      end else begin
         $display("Test FAILED");
      end
      $finish;
   end

endmodule

//--- filelist.f
+incdir+source
source/hdr_proc_pkg.sv
source/hdr_drop_filter.sv
source/hdr_prefix_insert.sv
source/hdr_trunc.sv
source/hdr_pkt_fifo.sv
source/hdr_proc.sv
sim/hdr_proc_properties.sv
sim/hdr_proc_tb.sv

//--- run_sim.sh
#!/usr/bin/env bash
# build the testbench with Verilator, run it into sim.log and judge the log.
cd "$(dirname "$0")" || exit 1
rm -f sim.log

verilator --binary --assert --top-module hdr_proc_tb -f filelist.f \
   && ./obj_dir/Vhdr_proc_tb > sim.log 2>&1 \
   || echo "Test FAILED" >> sim.log

cat sim.log
grep -q "Test FAILED" sim.log && exit 1 || exit 0
